//--- ctl_reg_bank.sv
/*
  sixteen 4-bit control registers written by set, clear and toggle frames
  address 11 restores reset values, unknown addresses are ignored and read 0
*/
`timescale 1ns/10ps
`default_nettype none

module ctl_reg_bank
  import smu_pkg::*;
(
  input  logic      clk,
  input  logic      arst_n,
  input  logic      frame_stb,
  input  reg_addr_t frame_addr,
  input  reg_val_t  frame_val,
  input  reg_addr_t rd_addr,
  output ctl_nib_t  rd_nib,
  output ctl_nib_t  led,
  output ctl_nib_t  mux,
  output ctl_nib_t  dac,
  output ctl_nib_t  rails,
  output ctl_nib_t  dac_ref_mux,
  output ctl_nib_t  adc,
  output ctl_nib_t  clamp1,
  output ctl_nib_t  clamp2,
  output ctl_nib_t  relay_com,
  output ctl_nib_t  irangex_sw,
  output ctl_nib_t  relay,
  output ctl_nib_t  irange_sense,
  output ctl_nib_t  ifb_gain,
  output ctl_nib_t  vfb_gain,
  output ctl_nib_t  rails_oe,
  output ctl_nib_t  ina_vfb_sw
);

  ctl_nib_t ctl_q [NUM_CTL_REGS];

  //////////////////////////////
  // register map

  // storage slot to bus address, slot order matches the port list
  function automatic reg_addr_t slot_addr(input int slot);
    case (slot)
      0:       slot_addr = ADDR_LED;
      1:       slot_addr = ADDR_MUX;
      2:       slot_addr = ADDR_DAC;
      3:       slot_addr = ADDR_RAILS;
      4:       slot_addr = ADDR_DAC_REF_MUX;
      5:       slot_addr = ADDR_ADC;
      6:       slot_addr = ADDR_CLAMP1;
      7:       slot_addr = ADDR_CLAMP2;
      8:       slot_addr = ADDR_RELAY_COM;
      9:       slot_addr = ADDR_IRANGEX_SW;
      10:      slot_addr = ADDR_RELAY;
      11:      slot_addr = ADDR_IRANGE_SENSE;
      12:      slot_addr = ADDR_IFB_GAIN;
      13:      slot_addr = ADDR_VFB_GAIN;
      14:      slot_addr = ADDR_RAILS_OE;
      // slot 15
      default: slot_addr = ADDR_INA_VFB_SW;
    endcase
  endfunction

  // shared by hard and soft reset
  function automatic ctl_nib_t rst_val(input int slot);
    if (slot_addr(slot) == ADDR_IRANGE_SENSE)
    begin
      rst_val = IRANGE_SENSE_RST;
    end
    else
    begin
      rst_val = '0;
    end
  endfunction

  // set low nibble, clear high nibble
  // bits named in both toggle and then nothing else changes
  function automatic ctl_nib_t upd(input ctl_nib_t old, input reg_val_t val);
    ctl_nib_t set_b;
    ctl_nib_t clr_b;
    ctl_nib_t both;
    set_b = val[3:0];
    clr_b = val[7:4];
    both  = set_b & clr_b;
    if (both != '0)
    begin
      upd = old ^ both;
    end
    else
    begin
      upd = (old | set_b) & ~clr_b;
    end
  endfunction

  //////////////////////////////
  // update

  always_ff @(posedge clk or negedge arst_n)
  begin
    if (!arst_n)
    begin
      for (int i = 0; i < NUM_CTL_REGS; i++)
      begin
        ctl_q[i] <= rst_val(i);
      end
    end
    else if (frame_stb)
    begin
      for (int i = 0; i < NUM_CTL_REGS; i++)
      begin
        if (frame_addr == ADDR_SOFT_RST)
        begin
          ctl_q[i] <= rst_val(i);
        end
        else if (frame_addr == slot_addr(i))
        begin
          ctl_q[i] <= upd(ctl_q[i], frame_val);
        end
      end
    end
  end

  // readback, zero for soft reset and unmapped addresses
  always_comb
  begin
    rd_nib = '0;
    for (int i = 0; i < NUM_CTL_REGS; i++)
    begin
      if (rd_addr == slot_addr(i))
      begin
        rd_nib = ctl_q[i];
      end
    end
  end

  assign led          = ctl_q[0];
  assign mux          = ctl_q[1];
  assign dac          = ctl_q[2];
  assign rails        = ctl_q[3];
  assign dac_ref_mux  = ctl_q[4];
  assign adc          = ctl_q[5];
  assign clamp1       = ctl_q[6];
  assign clamp2       = ctl_q[7];
  assign relay_com    = ctl_q[8];
  assign irangex_sw   = ctl_q[9];
  assign relay        = ctl_q[10];
  assign irange_sense = ctl_q[11];
  assign ifb_gain     = ctl_q[12];
  assign vfb_gain     = ctl_q[13];
  assign rails_oe     = ctl_q[14];
  assign ina_vfb_sw   = ctl_q[15];

endmodule

`default_nettype wire

//--- run.sh
#!/bin/sh
# build and run the smu control testbench with verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f sources.f --top-module tb_smu_ctl \
  --Mdir obj_dir -o sim_tb

if ! ./obj_dir/sim_tb > sim.log 2>&1; then
  cat sim.log
  echo "simulation aborted"
  exit 1
fi
cat sim.log

if grep -q '\*\*\* FAILED \*\*\*' sim.log; then
  exit 1
fi
exit 0

//--- smu_ctl_chk.sv
/*
  assertions bound into the control fpga top level
  covers routing during register bank frames, strobe width and reset values
*/
`timescale 1ns/10ps
`default_nettype none

module smu_ctl_chk
  import smu_pkg::*;
(
  input logic        clk,
  input logic        arst_n,
  input logic        special_n,
  input periph_vec_t periph_cs_n,
  input logic        frame_stb,
  input ctl_nib_t    led,
  input ctl_nib_t    mux,
  input ctl_nib_t    dac,
  input ctl_nib_t    rails,
  input ctl_nib_t    dac_ref_mux,
  input ctl_nib_t    adc,
  input ctl_nib_t    clamp1,
  input ctl_nib_t    clamp2,
  input ctl_nib_t    relay_com,
  input ctl_nib_t    irangex_sw,
  input ctl_nib_t    relay,
  input ctl_nib_t    irange_sense,
  input ctl_nib_t    ifb_gain,
  input ctl_nib_t    vfb_gain,
  input ctl_nib_t    rails_oe,
  input ctl_nib_t    ina_vfb_sw
);

  //////////////////////////////
  // routing and strobe

  // no peripheral sees a register bank frame
  cs_quiet_a : assert property (@(posedge clk) !special_n |-> periph_cs_n == 4'hf)
    else $error("peripheral chip select low while special_n is low");

  // one clk pulse per frame
  stb_single_a : assert property (@(posedge clk) disable iff (!arst_n)
    frame_stb |=> !frame_stb)
    else $error("frame_stb high on two consecutive clk");

  //////////////////////////////
  // reset values

  // eleven zero nibbles, irange sense, then four more zero nibbles
  rst_val_a : assert property (@(posedge clk) !arst_n |->
    ({led, mux, dac, rails, dac_ref_mux, adc, clamp1, clamp2, relay_com, irangex_sw,
      relay, irange_sense, ifb_gain, vfb_gain, rails_oe, ina_vfb_sw}
     == {44'h0, IRANGE_SENSE_RST, 16'h0}))
    else $error("control register away from its reset value during reset");

endmodule

bind smu_ctl_top smu_ctl_chk u_chk (.*);

`default_nettype wire

//--- smu_ctl_top.sv
/*
  smu control fpga, one mcu spi port plus special_n select
  sclk and mosi are shared with the peripherals outside the fpga
*/
`timescale 1ns/10ps
`default_nettype none

module smu_ctl_top
  import smu_pkg::*;
(
  input  logic        clk,
  input  logic        arst_n,
  input  logic        sclk,
  input  logic        spi_cs_n,
  input  logic        special_n,
  input  logic        mosi,
  input  periph_vec_t periph_miso,
  output logic        miso,
  output periph_vec_t periph_cs_n,
  output ctl_nib_t    led,
  output ctl_nib_t    mux,
  output ctl_nib_t    dac,
  output ctl_nib_t    rails,
  output ctl_nib_t    dac_ref_mux,
  output ctl_nib_t    adc,
  output ctl_nib_t    clamp1,
  output ctl_nib_t    clamp2,
  output ctl_nib_t    relay_com,
  output ctl_nib_t    irangex_sw,
  output ctl_nib_t    relay,
  output ctl_nib_t    irange_sense,
  output ctl_nib_t    ifb_gain,
  output ctl_nib_t    vfb_gain,
  output ctl_nib_t    rails_oe,
  output ctl_nib_t    ina_vfb_sw
);

  // decode to execute
  logic      frame_stb;
  reg_addr_t frame_addr;
  reg_val_t  frame_val;
  reg_addr_t rd_addr;
  ctl_nib_t  rd_nib;
  // register bank side of miso
  logic      rx_miso;

  //////////////////////////////
  // decode

  spi_frame_rx u_frame_rx (
    .clk        (clk),
    .arst_n     (arst_n),
    .sclk       (sclk),
    .spi_cs_n   (spi_cs_n),
    .special_n  (special_n),
    .mosi       (mosi),
    .rd_nib     (rd_nib),
    .rx_miso    (rx_miso),
    .frame_stb  (frame_stb),
    .frame_addr (frame_addr),
    .frame_val  (frame_val),
    .rd_addr    (rd_addr)
  );

  //////////////////////////////
  // execute

  ctl_reg_bank u_reg_bank (
    .clk          (clk),
    .arst_n       (arst_n),
    .frame_stb    (frame_stb),
    .frame_addr   (frame_addr),
    .frame_val    (frame_val),
    .rd_addr      (rd_addr),
    .rd_nib       (rd_nib),
    .led          (led),
    .mux          (mux),
    .dac          (dac),
    .rails        (rails),
    .dac_ref_mux  (dac_ref_mux),
    .adc          (adc),
    .clamp1       (clamp1),
    .clamp2       (clamp2),
    .relay_com    (relay_com),
    .irangex_sw   (irangex_sw),
    .relay        (relay),
    .irange_sense (irange_sense),
    .ifb_gain     (ifb_gain),
    .vfb_gain     (vfb_gain),
    .rails_oe     (rails_oe),
    .ina_vfb_sw   (ina_vfb_sw)
  );

  //////////////////////////////
  // routing

  // mux nibble picks the peripherals
  spi_route u_route (
    .spi_cs_n    (spi_cs_n),
    .special_n   (special_n),
    .sel         (mux),
    .rx_miso     (rx_miso),
    .periph_miso (periph_miso),
    .miso        (miso),
    .periph_cs_n (periph_cs_n)
  );

endmodule

`default_nettype wire

//--- smu_pkg.sv
/*
  widths, register map and reset values shared by the smu control fpga
  addresses outside this map are ignored by the register bank
*/
`default_nettype none

package smu_pkg;

  //////////////////////////////
  // widths

  // high byte of a frame
  typedef logic [7:0] reg_addr_t;
  // low nibble sets, high nibble clears
  typedef logic [7:0] reg_val_t;
  typedef logic [3:0] ctl_nib_t;
  // bit order from lsb is adc03 dac flash adc02
  typedef logic [3:0] periph_vec_t;

  localparam int FRAME_BITS   = 16;
  localparam int ADDR_BITS    = $bits(reg_addr_t);
  localparam int BIT_CNT_W    = 5;
  localparam int NUM_CTL_REGS = 16;

  typedef logic [BIT_CNT_W-1:0] bit_cnt_t;

  // count of the last address bit, a full frame, and the spoiled marker
  localparam bit_cnt_t CNT_ADDR_LAST = bit_cnt_t'(ADDR_BITS - 1);
  localparam bit_cnt_t CNT_FRAME     = bit_cnt_t'(FRAME_BITS);
  localparam bit_cnt_t CNT_SAT       = bit_cnt_t'(FRAME_BITS + 1);

  //////////////////////////////
  // register addresses

  localparam reg_addr_t ADDR_LED          = 8'd7;
  localparam reg_addr_t ADDR_MUX          = 8'd8;
  localparam reg_addr_t ADDR_DAC          = 8'd9;
  localparam reg_addr_t ADDR_RAILS        = 8'd10;
  localparam reg_addr_t ADDR_SOFT_RST     = 8'd11;
  localparam reg_addr_t ADDR_DAC_REF_MUX  = 8'd12;
  localparam reg_addr_t ADDR_ADC          = 8'd14;
  localparam reg_addr_t ADDR_CLAMP1       = 8'd15;
  localparam reg_addr_t ADDR_CLAMP2       = 8'd16;
  localparam reg_addr_t ADDR_RELAY_COM    = 8'd17;
  localparam reg_addr_t ADDR_IRANGEX_SW   = 8'd18;
  localparam reg_addr_t ADDR_RELAY        = 8'd19;
  localparam reg_addr_t ADDR_IRANGE_SENSE = 8'd20;
  localparam reg_addr_t ADDR_IFB_GAIN     = 8'd21;
  localparam reg_addr_t ADDR_VFB_GAIN     = 8'd23;
  localparam reg_addr_t ADDR_RAILS_OE     = 8'd24;
  localparam reg_addr_t ADDR_INA_VFB_SW   = 8'd25;

  // only irange sense comes up non zero
  localparam ctl_nib_t IRANGE_SENSE_RST = 4'b1111;

  typedef enum logic [1:0] {RX_IDLE, RX_ADDR, RX_VAL} rx_state_t;

endpackage

`default_nettype wire

//--- sources.f
smu_pkg.sv
spi_frame_rx.sv
ctl_reg_bank.sv
spi_route.sv
smu_ctl_top.sv
smu_ctl_chk.sv
tb_smu_ctl.sv

//--- spi_frame_rx.sv
/*
  spi mode 0 slave for the register bank, oversampled with clk
  sclk half period must span several clk, 8 clk gives a settled readback bit
  a frame counts only while special_n and spi_cs_n are both low
*/
`timescale 1ns/10ps
`default_nettype none

module spi_frame_rx
  import smu_pkg::*;
(
  input  logic      clk,
  input  logic      arst_n,
  input  logic      sclk,
  input  logic      spi_cs_n,
  input  logic      special_n,
  input  logic      mosi,
  input  ctl_nib_t  rd_nib,
  output logic      rx_miso,
  output logic      frame_stb,
  output reg_addr_t frame_addr,
  output reg_val_t  frame_val,
  output reg_addr_t rd_addr
);

  // pins in order sclk cs special mosi
  logic [3:0]            pin_meta;
  logic [3:0]            pin_sync;
  logic                  sclk_s;
  logic                  cs_s;
  logic                  special_s;
  logic                  mosi_s;
  logic                  sclk_d;
  logic                  cs_d;
  logic                  sclk_rise;
  logic                  sclk_fall;
  logic                  cs_rise;
  logic                  shift_en;
  rx_state_t             state;
  bit_cnt_t              bit_cnt;
  logic [FRAME_BITS-1:0] rx_sh;
  reg_val_t              tx_sh;
  logic                  ld_pend;

  //////////////////////////////
  // synchronizer and edge detect

  always_ff @(posedge clk or negedge arst_n)
  begin
    if (!arst_n)
    begin
      // idle bus with sclk low and both selects high
      pin_meta <= 4'b0110;
      pin_sync <= 4'b0110;
      sclk_d   <= 1'b0;
      cs_d     <= 1'b1;
    end
    else
    begin
      pin_meta <= {sclk, spi_cs_n, special_n, mosi};
      pin_sync <= pin_meta;
      sclk_d   <= sclk_s;
      cs_d     <= cs_s;
    end
  end

  assign {sclk_s, cs_s, special_s, mosi_s} = pin_sync;
  assign sclk_rise = sclk_s & ~sclk_d;
  assign sclk_fall = ~sclk_s & sclk_d;
  assign cs_rise   = cs_s & ~cs_d;
  // mosi is sampled on rises of our own frames only
  assign shift_en  = sclk_rise & ~cs_s & ~special_s;

  //////////////////////////////
  // bit count fsm and strobe

  always_ff @(posedge clk or negedge arst_n)
  begin
    if (!arst_n)
    begin
      state     <= RX_IDLE;
      bit_cnt   <= '0;
      ld_pend   <= 1'b0;
      frame_stb <= 1'b0;
    end
    else
    begin
      ld_pend   <= 1'b0;
      // count still holds the finished frame at the cs rise
      frame_stb <= cs_rise && (state == RX_VAL) && (bit_cnt == CNT_FRAME);
      if (cs_s)
      begin
        state   <= RX_IDLE;
        bit_cnt <= '0;
      end
      else if (special_s)
      begin
        // special dropped mid frame so mark it spoiled
        if (state != RX_IDLE)
        begin
          bit_cnt <= CNT_SAT;
        end
      end
      else
      begin
        if (state == RX_IDLE)
        begin
          state <= RX_ADDR;
        end
        if (sclk_rise)
        begin
          // saturate so a long frame never wraps to 16
          if (bit_cnt != CNT_SAT)
          begin
            bit_cnt <= bit_cnt + 1'b1;
          end
          // eighth rise completes the address
          if (bit_cnt == CNT_ADDR_LAST)
          begin
            state   <= RX_VAL;
            ld_pend <= 1'b1;
          end
        end
      end
    end
  end

  //////////////////////////////
  // shift registers

  always_ff @(posedge clk)
  begin
    if (shift_en)
    begin
      rx_sh <= {rx_sh[FRAME_BITS-2:0], mosi_s};
      if (bit_cnt == CNT_ADDR_LAST)
      begin
        rd_addr <= {rx_sh[ADDR_BITS-2:0], mosi_s};
      end
    end
    // rd_nib is valid one clk after rd_addr
    if (ld_pend)
    begin
      tx_sh <= {4'b0000, rd_nib};
    end
    else if (sclk_fall && (state == RX_VAL))
    begin
      tx_sh <= {tx_sh[6:0], 1'b0};
    end
  end

  // readback msb first, zero during the address byte
  always_ff @(posedge clk or negedge arst_n)
  begin
    if (!arst_n)
    begin
      rx_miso <= 1'b0;
    end
    else if (cs_s || special_s)
    begin
      rx_miso <= 1'b0;
    end
    else if (sclk_fall)
    begin
      rx_miso <= (state == RX_VAL) & tx_sh[7];
    end
  end

  assign frame_addr = rx_sh[FRAME_BITS-1 -: ADDR_BITS];
  assign frame_val  = rx_sh[ADDR_BITS-1:0];

endmodule

`default_nettype wire

//--- spi_route.sv
/*
  combinational routing of the shared spi bus to four peripherals
  several select bits may be set, their miso lines are or-ed
*/
`timescale 1ns/10ps
`default_nettype none

module spi_route
  import smu_pkg::*;
(
  input  logic        spi_cs_n,
  input  logic        special_n,
  input  periph_vec_t sel,
  input  logic        rx_miso,
  input  periph_vec_t periph_miso,
  output logic        miso,
  output periph_vec_t periph_cs_n
);

  //////////////////////////////
  // chip select demux

  always_comb
  begin
    // register bank frames never reach a peripheral
    periph_cs_n = '1;
    if (special_n && !spi_cs_n)
    begin
      periph_cs_n = ~sel;
    end
  end

  //////////////////////////////
  // miso mux

  // unselected peripherals are masked off
  assign miso = special_n ? |(sel & periph_miso) : rx_miso;

endmodule

`default_nettype wire

//--- tb_smu_ctl.sv
/*
  testbench for the smu control fpga, bit-bangs spi mode 0 with 8 clk half periods
  register outputs are compared with a nibble model after every frame
*/
`timescale 1ns/10ps
`default_nettype none

module tb_smu_ctl
  import smu_pkg::*;
();

  localparam int HALF_CLKS  = 8;
  // one frame plus select setup and the settle time after it
  localparam int FRAME_CLKS = FRAME_BITS * 2 * HALF_CLKS + 16;
  localparam int MAX_CYCLES = 300 * FRAME_CLKS + 2000;
  localparam int N_RANDOM   = 200;
  localparam int N_ROUTE    = 20;

  logic        clk;
  logic        arst_n;
  logic        sclk;
  logic        spi_cs_n;
  logic        special_n;
  logic        mosi;
  periph_vec_t periph_miso;
  logic        miso;
  periph_vec_t periph_cs_n;
  ctl_nib_t    dut_q [16];

  // model slot order follows the output ports of the top level
  ctl_nib_t  model [16];
  reg_addr_t addr_tab [16] = '{ADDR_LED, ADDR_MUX, ADDR_DAC, ADDR_RAILS, ADDR_DAC_REF_MUX,
                               ADDR_ADC, ADDR_CLAMP1, ADDR_CLAMP2, ADDR_RELAY_COM,
                               ADDR_IRANGEX_SW, ADDR_RELAY, ADDR_IRANGE_SENSE,
                               ADDR_IFB_GAIN, ADDR_VFB_GAIN, ADDR_RAILS_OE, ADDR_INA_VFB_SW};
  integer    seed;
  int        checks = 0;
  int        errors = 0;
  int        tests  = 0;
  int        cycles = 0;

  smu_ctl_top u_smu_ctl_top (
    .clk          (clk),
    .arst_n       (arst_n),
    .sclk         (sclk),
    .spi_cs_n     (spi_cs_n),
    .special_n    (special_n),
    .mosi         (mosi),
    .periph_miso  (periph_miso),
    .miso         (miso),
    .periph_cs_n  (periph_cs_n),
    .led          (dut_q[0]),
    .mux          (dut_q[1]),
    .dac          (dut_q[2]),
    .rails        (dut_q[3]),
    .dac_ref_mux  (dut_q[4]),
    .adc          (dut_q[5]),
    .clamp1       (dut_q[6]),
    .clamp2       (dut_q[7]),
    .relay_com    (dut_q[8]),
    .irangex_sw   (dut_q[9]),
    .relay        (dut_q[10]),
    .irange_sense (dut_q[11]),
    .ifb_gain     (dut_q[12]),
    .vfb_gain     (dut_q[13]),
    .rails_oe     (dut_q[14]),
    .ina_vfb_sw   (dut_q[15])
  );

  //////////////////////////////
  // clock and run limit

  initial
  begin
    // start low so the first rise comes at 10 ns
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  always @(posedge clk)
  begin
    cycles = cycles + 1;
    if (cycles >= MAX_CYCLES)
    begin
      $display("timeout: the run went past %0d clk cycles without finishing", MAX_CYCLES);
      $display("*** FAILED ***");
      $finish;
    end
  end

  //////////////////////////////
  // model

  // toggle when a bit is named twice, else set then clear
  function automatic ctl_nib_t next_nib(input ctl_nib_t cur, input reg_val_t val);
    ctl_nib_t tog;
    tog = val[3:0] & val[7:4];
    if (tog != 4'h0)
    begin
      next_nib = cur ^ tog;
    end
    else
    begin
      next_nib = (cur & ~val[7:4]) | val[3:0];
    end
  endfunction

  // -1 for addresses outside the map
  function automatic int slot_of(input reg_addr_t a);
    slot_of = -1;
    for (int i = 0; i < 16; i++)
    begin
      if (addr_tab[i] == a)
      begin
        slot_of = i;
      end
    end
  endfunction

  task automatic model_reset();
    for (int i = 0; i < 16; i++)
    begin
      model[i] = (addr_tab[i] == ADDR_IRANGE_SENSE) ? IRANGE_SENSE_RST : 4'h0;
    end
  endtask

  //////////////////////////////
  // checks

  task automatic check(input string name, input logic [15:0] exp, input logic [15:0] act);
    checks++;
    if (exp !== act)
    begin
      errors++;
      $display("Fail %s expected %0h actual %0h", name, exp, act);
    end
  endtask

  task automatic check_outputs(input string name);
    for (int i = 0; i < 16; i++)
    begin
      check($sformatf("%s reg %0d", name, addr_tab[i]), {12'h0, model[i]}, {12'h0, dut_q[i]});
    end
  endtask

  task automatic end_test(input string name, input int err0);
    tests++;
    $display("test %s done with %0d errors", name, errors - err0);
  endtask

  //////////////////////////////
  // spi master

  // msb first, returns miso sampled just before each rise
  task automatic spi_frame(input int nbits, input logic [16:0] data, output logic [15:0] rb);
    rb = '0;
    @(negedge clk);
    special_n = 1'b0;
    spi_cs_n  = 1'b0;
    sclk      = 1'b0;
    for (int i = 0; i < nbits; i++)
    begin
      mosi = data[nbits-1-i];
      repeat (HALF_CLKS) @(negedge clk);
      rb   = {rb[14:0], miso};
      sclk = 1'b1;
      repeat (HALF_CLKS) @(negedge clk);
      sclk = 1'b0;
    end
    repeat (HALF_CLKS) @(negedge clk);
    // cs rise executes, special drops a clk later
    spi_cs_n = 1'b1;
    @(negedge clk);
    special_n = 1'b1;
    mosi      = 1'b0;
    // registers settle 4 clk after the cs rise
    repeat (6) @(negedge clk);
  endtask

  // full frame, readback expected from the model before the update
  task automatic frame_and_model(input reg_addr_t a, input reg_val_t v, input string name,
                                 input bit check_rb);
    int          s;
    logic [15:0] exp_rb;
    logic [15:0] rb;
    s = slot_of(a);
    exp_rb = 16'h0;
    if (s >= 0)
    begin
      exp_rb = {12'h0, model[s]};
    end
    spi_frame(16, {1'b0, a, v}, rb);
    if (check_rb)
    begin
      check({name, " readback"}, exp_rb, rb);
    end
    if (s >= 0)
    begin
      model[s] = next_nib(model[s], v);
    end
    else if (a == ADDR_SOFT_RST)
    begin
      model_reset();
    end
  endtask

  //////////////////////////////
  // test sequence

  initial
  begin
    int          slot;
    int          err0;
    logic [31:0] r;
    periph_vec_t m;
    logic [15:0] rb;
    seed        = 66310;
    arst_n      = 1'b1;
    sclk        = 1'b0;
    spi_cs_n    = 1'b1;
    special_n   = 1'b1;
    mosi        = 1'b0;
    periph_miso = '0;
    model_reset();
    @(negedge clk);
    arst_n = 1'b0;
    repeat (5) @(negedge clk);
    arst_n = 1'b1;
    @(negedge clk);

    // reset values
    err0 = errors;
    check_outputs("reset");
    check("reset periph_cs_n", 16'h000f, {12'h0, periph_cs_n});
    end_test("reset", err0);

    // random set, clear and toggle frames, soft reset excluded
    err0 = errors;
    for (int n = 0; n < N_RANDOM; n++)
    begin
      slot = $unsigned($random(seed)) % 16;
      r    = $random(seed);
      frame_and_model(addr_tab[slot], r[7:0], "random", 1'b1);
      check_outputs("random");
    end
    end_test("random_updates", err0);

    // zero value frames change nothing and only read
    err0 = errors;
    for (int i = 0; i < 16; i++)
    begin
      frame_and_model(addr_tab[i], 8'h00, "readback", 1'b1);
    end
    check_outputs("readback");
    end_test("readback", err0);

    // dac cleared first so a stray set would show
    err0 = errors;
    frame_and_model(ADDR_DAC, 8'hf0, "dac clear", 1'b0);
    // with the zero bit left from the last frame these 15 bits would set dac
    spi_frame(15, {2'b00, ADDR_DAC[6:0], 8'h0f}, rb);
    check_outputs("short frame");
    spi_frame(17, {ADDR_DAC, 8'h0f, 1'b1}, rb);
    check_outputs("long frame");
    frame_and_model(8'd13, 8'h0f, "addr 13", 1'b1);
    check_outputs("addr 13");
    frame_and_model(8'd22, 8'h0f, "addr 22", 1'b1);
    check_outputs("addr 22");
    end_test("rejected", err0);

    // soft reset
    err0 = errors;
    r = $random(seed);
    frame_and_model(ADDR_SOFT_RST, r[7:0], "soft reset", 1'b1);
    check_outputs("soft reset");
    check("soft reset periph_cs_n", 16'h000f, {12'h0, periph_cs_n});
    end_test("soft_reset", err0);

    // routing, mux written as set m and clear the rest
    err0 = errors;
    for (int n = 0; n < N_ROUTE; n++)
    begin
      r = $random(seed);
      m = r[3:0];
      frame_and_model(ADDR_MUX, {~m, m}, "route mux", 1'b0);
      check("route mux", {12'h0, m}, {12'h0, dut_q[1]});
      r           = $random(seed);
      spi_cs_n    = r[0];
      periph_miso = r[4:1];
      @(negedge clk);
      check("route cs", {12'h0, (spi_cs_n ? 4'hf : ~m)}, {12'h0, periph_cs_n});
      check("route miso", {15'h0, |(m & periph_miso)}, {15'h0, miso});
      // register bank side holds every peripheral off
      spi_cs_n  = 1'b1;
      special_n = 1'b0;
      @(negedge clk);
      spi_cs_n = 1'b0;
      @(negedge clk);
      check("route special cs", 16'h000f, {12'h0, periph_cs_n});
      check("route special miso", 16'h0000, {15'h0, miso});
      spi_cs_n = 1'b1;
      @(negedge clk);
      special_n   = 1'b1;
      periph_miso = '0;
      @(negedge clk);
    end
    end_test("routing", err0);

    $display("summary: %0d tests, %0d checks, %0d errors", tests, checks, errors);
    if (errors == 0)
    begin
      $display("*** PASSED ***");
    end
    else
    begin
      $display("*** FAILED ***");
    end
    $finish;
  end

endmodule

`default_nettype wire
